// File: Makefile
# Verilator build and run for the LMS front end testbench
# Override any variable on the command line, e.g. make test OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= lms_frontend_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, pass if the output holds the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: common/lms_pkg.sv
// Widths assume the LMS6002D 12-bit parallel sample bus in interleaved I/Q mode
package lms_pkg;

   // Transceiver bus word, shared by ADC and DAC sides
   parameter int SAMPLE_W = 12;

   // Core sample width seen by the DSP chain
   parameter int CORE_W = 14;

   // Zero bits appended below a received word
   parameter int PAD_W = CORE_W - SAMPLE_W;

   // Aux DAC, LMS 1, LMS 2 in index order
   parameter int NUM_SPI_DEV = 3;

   // One word on the LMS data bus
   typedef logic [SAMPLE_W-1:0] lms_word_t;

   // Received I or Q sample, left-aligned to the core width
   typedef logic [CORE_W-1:0] adc_sample_t;

   // Transmit I or Q sample, same width as the bus
   typedef logic [SAMPLE_W-1:0] dac_sample_t;

endpackage

// File: compile.f
common/lms_pkg.sv
lms_rx/lms_rx_deinterleave.sv
lms_tx/lms_tx_interleave.sv
source/lms_spi_router.sv
source/lms_frontend_top.sv
verification/lms_frontend_tb.sv

// File: lms_rx/lms_rx_deinterleave.sv
// ADC words arrive every cycle with IQSEL high for I; the ADC cannot be stalled, so no ready
module lms_rx_deinterleave
(
   input  logic                 lms_clk,
   input  logic                 rst_n_i,

   // LMS ADC bus
   input  logic                 rx_iqsel_i,  // High marks an I word
   input  lms_pkg::lms_word_t   rx_data_i,

   // Core side, one pulse per pair
   output lms_pkg::adc_sample_t rx_i_o,
   output lms_pkg::adc_sample_t rx_q_o,
   output logic                 rx_valid_o
);

   lms_pkg::lms_word_t i_word;  // Last I word seen
   logic               i_held;  // I word waiting for its Q

   // I word capture, qualified by i_held
   always_ff @(posedge lms_clk)
   begin
      if (rx_iqsel_i)
      begin
         i_word <= rx_data_i;  // A later I simply overwrites
      end
   end

   always_ff @(posedge lms_clk)
   begin
      if (!rst_n_i)
      begin
         i_held     <= 1'b0;
         rx_i_o     <= '0;
         rx_q_o     <= '0;
         rx_valid_o <= 1'b0;
      end
      else
      begin
         rx_valid_o <= 1'b0;  // Single-cycle strobe
         if (rx_iqsel_i)
         begin
            i_held <= 1'b1;
         end
         else if (i_held)
         begin
            // Q completes the pair; left-align both to core width
            rx_i_o     <= {i_word, {lms_pkg::PAD_W{1'b0}}};
            rx_q_o     <= {rx_data_i, {lms_pkg::PAD_W{1'b0}}};
            rx_valid_o <= 1'b1;
            i_held     <= 1'b0;
         end
         // Q with no pending I is dropped
      end
   end

   // A pair needs an I and a Q word, so two strobes can never touch
   a_valid_single : assert property (
      @(posedge lms_clk) rx_valid_o |=> !rx_valid_o
   ) else $error("rx_valid_o high for two consecutive cycles");

endmodule

// File: lms_tx/lms_tx_interleave.sv
// DAC runs at twice the pair rate; upstream must hold valid until ready, pairs are never dropped
module lms_tx_interleave
(
   input  logic                 lms_clk,
   input  logic                 rst_n_i,

   // Core side, valid/ready
   input  lms_pkg::dac_sample_t tx_i_i,
   input  lms_pkg::dac_sample_t tx_q_i,
   input  logic                 tx_valid_i,
   output logic                 tx_ready_o,

   // LMS DAC bus
   output lms_pkg::lms_word_t   tx_data_o,
   output logic                 tx_iqsel_o  // Low during I slot, high during Q slot
);

   logic                 slot_tgl;  // High while the Q slot is on the bus
   logic                 accept;
   lms_pkg::dac_sample_t q_hold;    // Q sample waiting for its slot

   // Next bus slot is I whenever the current one is Q
   assign tx_ready_o = slot_tgl;
   assign tx_iqsel_o = slot_tgl;

   assign accept = tx_valid_i && slot_tgl;

   // Q is staged at every I-slot edge, zero when nothing was taken
   always_ff @(posedge lms_clk)
   begin
      if (slot_tgl)
      begin
         q_hold <= accept ? tx_q_i : '0;
      end
   end

   always_ff @(posedge lms_clk)
   begin
      if (!rst_n_i)
      begin
         slot_tgl  <= 1'b1;  // First slot after reset is I
         tx_data_o <= '0;
      end
      else
      begin
         slot_tgl <= ~slot_tgl;
         if (slot_tgl)
         begin
            // Entering I slot
            tx_data_o <= accept ? tx_i_i : '0;
         end
         else
         begin
            tx_data_o <= q_hold;  // Entering Q slot
         end
      end
   end

   // IQSEL is free-running once out of reset
   a_iqsel_toggle : assert property (
      @(posedge lms_clk)
      rst_n_i && $past(rst_n_i) |-> (tx_iqsel_o != $past(tx_iqsel_o))
   ) else $error("tx_iqsel_o did not alternate");

   // Upstream must not withdraw a pair before it is taken
   a_valid_hold : assert property (
      @(posedge lms_clk)
      rst_n_i && tx_valid_i && !tx_ready_o |=> tx_valid_i
   ) else $error("tx_valid_i dropped before acceptance");

endmodule

// File: source/lms_frontend_top.sv
// Two LMS6002D sample paths plus SPI routing on lms_clk rising edges; TXEN/RXEN tied off-chip
module lms_frontend_top
(
   input  logic                                lms_clk,
   input  logic                                rst_n_i,

   // ADC buses from the transceivers
   input  logic                                rx1_iqsel_i,
   input  lms_pkg::lms_word_t                  rx1_data_i,
   input  logic                                rx2_iqsel_i,
   input  lms_pkg::lms_word_t                  rx2_data_i,

   // Received pairs to the core
   output lms_pkg::adc_sample_t                adc1_i_o,
   output lms_pkg::adc_sample_t                adc1_q_o,
   output logic                                adc1_valid_o,
   output lms_pkg::adc_sample_t                adc2_i_o,
   output lms_pkg::adc_sample_t                adc2_q_o,
   output logic                                adc2_valid_o,

   // Transmit pairs from the core
   input  lms_pkg::dac_sample_t                dac1_i_i,
   input  lms_pkg::dac_sample_t                dac1_q_i,
   input  logic                                dac1_valid_i,
   input  lms_pkg::dac_sample_t                dac2_i_i,
   input  lms_pkg::dac_sample_t                dac2_q_i,
   input  logic                                dac2_valid_i,

   // DAC buses to the transceivers
   output logic                                dac1_ready_o,
   output logic                                dac2_ready_o,
   output lms_pkg::lms_word_t                  tx1_data_o,
   output logic                                tx1_iqsel_o,
   output lms_pkg::lms_word_t                  tx2_data_o,
   output logic                                tx2_iqsel_o,

   // SPI with device order aux DAC, LMS 1, LMS 2
   input  logic                                spi_sclk_i,
   input  logic                                spi_mosi_i,
   input  logic [lms_pkg::NUM_SPI_DEV-1:0]     spi_sen_n_i,
   output logic                                spi_miso_o,
   output logic [lms_pkg::NUM_SPI_DEV-1:0]     dev_sclk_o,
   output logic [lms_pkg::NUM_SPI_DEV-1:0]     dev_mosi_o,
   input  logic [lms_pkg::NUM_SPI_DEV-1:0]     dev_miso_i
);

   lms_rx_deinterleave u_rx1 (
      .lms_clk    (lms_clk),
      .rst_n_i    (rst_n_i),
      .rx_iqsel_i (rx1_iqsel_i),
      .rx_data_i  (rx1_data_i),
      .rx_i_o     (adc1_i_o),
      .rx_q_o     (adc1_q_o),
      .rx_valid_o (adc1_valid_o)
   );

   lms_rx_deinterleave u_rx2 (
      .lms_clk    (lms_clk),
      .rst_n_i    (rst_n_i),
      .rx_iqsel_i (rx2_iqsel_i),
      .rx_data_i  (rx2_data_i),
      .rx_i_o     (adc2_i_o),
      .rx_q_o     (adc2_q_o),
      .rx_valid_o (adc2_valid_o)
   );

   lms_tx_interleave u_tx1 (
      .lms_clk    (lms_clk),
      .rst_n_i    (rst_n_i),
      .tx_i_i     (dac1_i_i),
      .tx_q_i     (dac1_q_i),
      .tx_valid_i (dac1_valid_i),
      .tx_ready_o (dac1_ready_o),
      .tx_data_o  (tx1_data_o),
      .tx_iqsel_o (tx1_iqsel_o)
   );

   lms_tx_interleave u_tx2 (
      .lms_clk    (lms_clk),
      .rst_n_i    (rst_n_i),
      .tx_i_i     (dac2_i_i),
      .tx_q_i     (dac2_q_i),
      .tx_valid_i (dac2_valid_i),
      .tx_ready_o (dac2_ready_o),
      .tx_data_o  (tx2_data_o),
      .tx_iqsel_o (tx2_iqsel_o)
   );

   // Aux DAC and both transceivers share one master
   lms_spi_router #(
      .NUM_DEV (lms_pkg::NUM_SPI_DEV)
   ) u_spi (
      .lms_clk     (lms_clk),
      .rst_n_i     (rst_n_i),
      .spi_sclk_i  (spi_sclk_i),
      .spi_mosi_i  (spi_mosi_i),
      .spi_sen_n_i (spi_sen_n_i),
      .spi_miso_o  (spi_miso_o),
      .dev_miso_i  (dev_miso_i),
      .dev_sclk_o  (dev_sclk_o),
      .dev_mosi_o  (dev_mosi_o)
   );

endmodule

// File: source/lms_spi_router.sv
// Combinational SPI fan-out; the master must enable at most one device at a time
module lms_spi_router
#(
   parameter int NUM_DEV = 1
)
(
   input  logic               lms_clk,      // Only samples the enable check
   input  logic               rst_n_i,

   // Shared SPI master
   input  logic               spi_sclk_i,
   input  logic               spi_mosi_i,
   input  logic [NUM_DEV-1:0] spi_sen_n_i,  // Active-low enables
   output logic               spi_miso_o,

   // Per-device lines
   input  logic [NUM_DEV-1:0] dev_miso_i,
   output logic [NUM_DEV-1:0] dev_sclk_o,
   output logic [NUM_DEV-1:0] dev_mosi_o
);

   logic [NUM_DEV-1:0] dev_en;   // Active-high selects
   logic [NUM_DEV-1:0] dev_out;  // Selects that may drive outward

   assign dev_en  = ~spi_sen_n_i;
   assign dev_out = dev_en & {NUM_DEV{rst_n_i}};  // Quiet bus while in reset

   // Only the selected device sees clock and data
   assign dev_sclk_o = dev_out & {NUM_DEV{spi_sclk_i}};
   assign dev_mosi_o = dev_out & {NUM_DEV{spi_mosi_i}};

   // Unselected devices cannot disturb the return line
   assign spi_miso_o = |(dev_en & dev_miso_i);

   // Merged MISO is only meaningful with a single device selected
   a_one_enable : assert property (
      @(posedge lms_clk) rst_n_i |-> $onehot0(dev_en)
   ) else $error("more than one SPI device enabled");

endmodule

// File: verification/lms_frontend_tb.sv
// Needs verification/lms_frontend_testdata.txt reachable from the run directory; stops at first error
module lms_frontend_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int MAX_REC = 64;
   localparam int REC_W   = 8;     // Fields per record, kind first

   logic lms_clk = 1'b0;
   logic rst_n_i;

   logic                                rx1_iqsel_i;
   lms_pkg::lms_word_t                  rx1_data_i;
   logic                                rx2_iqsel_i;
   lms_pkg::lms_word_t                  rx2_data_i;
   lms_pkg::adc_sample_t                adc1_i_o;
   lms_pkg::adc_sample_t                adc1_q_o;
   logic                                adc1_valid_o;
   lms_pkg::adc_sample_t                adc2_i_o;
   lms_pkg::adc_sample_t                adc2_q_o;
   logic                                adc2_valid_o;
   lms_pkg::dac_sample_t                dac1_i_i;
   lms_pkg::dac_sample_t                dac1_q_i;
   logic                                dac1_valid_i;
   lms_pkg::dac_sample_t                dac2_i_i;
   lms_pkg::dac_sample_t                dac2_q_i;
   logic                                dac2_valid_i;
   logic                                dac1_ready_o;
   logic                                dac2_ready_o;
   lms_pkg::lms_word_t                  tx1_data_o;
   logic                                tx1_iqsel_o;
   lms_pkg::lms_word_t                  tx2_data_o;
   logic                                tx2_iqsel_o;
   logic                                spi_sclk_i;
   logic                                spi_mosi_i;
   logic [lms_pkg::NUM_SPI_DEV-1:0]     spi_sen_n_i;
   logic                                spi_miso_o;
   logic [lms_pkg::NUM_SPI_DEV-1:0]     dev_sclk_o;
   logic [lms_pkg::NUM_SPI_DEV-1:0]     dev_mosi_o;
   logic [lms_pkg::NUM_SPI_DEV-1:0]     dev_miso_i;

   logic [15:0] tdata [0:MAX_REC*REC_W-1];
   logic [15:0] rec   [0:REC_W-1];  // Record being run
   int          num_rec = 0;
   integer      seed = 55;

   always #50 lms_clk = ~lms_clk;

   lms_frontend_top u_lms_frontend_top (.*);

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_adc(input lms_pkg::adc_sample_t got, input lms_pkg::adc_sample_t exp,
                            input string what);
      if (got !== exp)
         fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic check_dac(input lms_pkg::lms_word_t got, input lms_pkg::lms_word_t exp,
                            input string what);
      if (got !== exp)
         fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
         fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
   endtask

   // One ADC word, checked after the edge that samples it
   task automatic rx_step;
      logic ch2;
      ch2 = (rec[1] == 16'd2);
      @(posedge lms_clk);
      if (ch2)
      begin
         rx2_iqsel_i <= rec[2][0];
         rx2_data_i  <= rec[3][lms_pkg::SAMPLE_W-1:0];
      end
      else
      begin
         rx1_iqsel_i <= rec[2][0];
         rx1_data_i  <= rec[3][lms_pkg::SAMPLE_W-1:0];
      end
      @(posedge lms_clk);
      @(negedge lms_clk);
      check_bit(ch2 ? adc2_valid_o : adc1_valid_o, rec[4][0], "adc valid");
      if (rec[4][0])
      begin
         check_adc(ch2 ? adc2_i_o : adc1_i_o, rec[5][lms_pkg::CORE_W-1:0], "adc I");
         check_adc(ch2 ? adc2_q_o : adc1_q_o, rec[6][lms_pkg::CORE_W-1:0], "adc Q");
      end
   endtask

   // Random idle gap, then one pair through the handshake and onto the bus
   task automatic tx_pair;
      logic ch2;
      int   gap;
      int   waits;
      ch2   = (rec[1] == 16'd2);
      gap   = $unsigned($random(seed)) % 4;
      waits = 0;
      repeat (gap)
      begin
         @(posedge lms_clk);
         @(negedge lms_clk);
         check_dac(ch2 ? tx2_data_o : tx1_data_o, '0, "idle slot data");
      end
      @(posedge lms_clk);
      if (ch2)
      begin
         dac2_i_i     <= rec[2][lms_pkg::SAMPLE_W-1:0];
         dac2_q_i     <= rec[3][lms_pkg::SAMPLE_W-1:0];
         dac2_valid_i <= 1'b1;
      end
      else
      begin
         dac1_i_i     <= rec[2][lms_pkg::SAMPLE_W-1:0];
         dac1_q_i     <= rec[3][lms_pkg::SAMPLE_W-1:0];
         dac1_valid_i <= 1'b1;
      end
      @(negedge lms_clk);
      while (!(ch2 ? dac2_ready_o : dac1_ready_o))
      begin
         waits++;
         if (waits > 2)
            fail_run($sformatf("DAC channel ready never went high at %0t", $time));
         @(posedge lms_clk);
         @(negedge lms_clk);
      end
      @(posedge lms_clk);  // Pair taken here
      dac1_valid_i <= 1'b0;
      dac2_valid_i <= 1'b0;
      @(negedge lms_clk);
      check_dac(ch2 ? tx2_data_o : tx1_data_o, rec[4][lms_pkg::SAMPLE_W-1:0], "I slot data");
      check_bit(ch2 ? tx2_iqsel_o : tx1_iqsel_o, 1'b0, "I slot iqsel");
      @(negedge lms_clk);
      check_dac(ch2 ? tx2_data_o : tx1_data_o, rec[5][lms_pkg::SAMPLE_W-1:0], "Q slot data");
      check_bit(ch2 ? tx2_iqsel_o : tx1_iqsel_o, 1'b1, "Q slot iqsel");
   endtask

   // Router is combinational, checked half a cycle later
   task automatic spi_step;
      logic [lms_pkg::NUM_SPI_DEV-1:0] got_sclk;
      logic [lms_pkg::NUM_SPI_DEV-1:0] got_mosi;
      logic [lms_pkg::NUM_SPI_DEV-1:0] exp_sclk;
      logic [lms_pkg::NUM_SPI_DEV-1:0] exp_mosi;
      @(posedge lms_clk);
      spi_sen_n_i <= rec[1][lms_pkg::NUM_SPI_DEV-1:0];
      spi_sclk_i  <= rec[2][0];
      spi_mosi_i  <= rec[3][0];
      dev_miso_i  <= rec[4][lms_pkg::NUM_SPI_DEV-1:0];
      @(negedge lms_clk);
      got_sclk = dev_sclk_o;
      got_mosi = dev_mosi_o;
      exp_sclk = rec[5][lms_pkg::NUM_SPI_DEV-1:0];
      exp_mosi = rec[6][lms_pkg::NUM_SPI_DEV-1:0];
      for (int d = 0; d < lms_pkg::NUM_SPI_DEV; d++)
      begin
         check_bit(got_sclk[0], exp_sclk[0], $sformatf("dev %0d sclk", d));
         check_bit(got_mosi[0], exp_mosi[0], $sformatf("dev %0d mosi", d));
         got_sclk = got_sclk >> 1;
         got_mosi = got_mosi >> 1;
         exp_sclk = exp_sclk >> 1;
         exp_mosi = exp_mosi >> 1;
      end
      check_bit(spi_miso_o, rec[7][0], "merged miso");
   endtask

   // Limit scales with the number of records
   initial
   begin : watchdog
      int limit_ns;
      wait (num_rec > 0);
      limit_ns = num_rec * 20 * 100;
      #(limit_ns);
      fail_run($sformatf("timeout, the run did not finish within %0d ns", limit_ns));
   end

   initial
   begin : main
      int n;
      rst_n_i      <= 1'b0;
      rx1_iqsel_i  <= 1'b0;
      rx1_data_i   <= '0;
      rx2_iqsel_i  <= 1'b0;
      rx2_data_i   <= '0;
      dac1_i_i     <= '0;
      dac1_q_i     <= '0;
      dac1_valid_i <= 1'b0;
      dac2_i_i     <= '0;
      dac2_q_i     <= '0;
      dac2_valid_i <= 1'b0;
      spi_sclk_i   <= 1'b1;      // Router must stay quiet in reset
      spi_mosi_i   <= 1'b1;
      spi_sen_n_i  <= 3'b110;
      dev_miso_i   <= '0;
      for (int i = 0; i < MAX_REC*REC_W; i++)
         tdata[i] = '0;
      $readmemh("verification/lms_frontend_testdata.txt", tdata);
      n = 0;
      while (n < MAX_REC && tdata[n*REC_W] >= 16'd1 && tdata[n*REC_W] <= 16'd3)
         n++;
      if (n == 0)
         fail_run("no test records found in verification/lms_frontend_testdata.txt");
      num_rec = n;

      repeat (8) @(posedge lms_clk);
      @(negedge lms_clk);
      check_bit(|dev_sclk_o, 1'b0, "dev sclk in reset");
      check_bit(|dev_mosi_o, 1'b0, "dev mosi in reset");
      repeat (8) @(posedge lms_clk);
      rst_n_i     <= 1'b1;
      spi_sen_n_i <= '1;
      spi_sclk_i  <= 1'b0;
      spi_mosi_i  <= 1'b0;

      // First cycle after release
      @(negedge lms_clk);
      check_bit(adc1_valid_o, 1'b0, "adc1 valid after reset");
      check_bit(adc2_valid_o, 1'b0, "adc2 valid after reset");
      check_bit(tx1_iqsel_o, 1'b1, "tx1 iqsel after reset");
      check_bit(tx2_iqsel_o, 1'b1, "tx2 iqsel after reset");
      check_dac(tx1_data_o, '0, "tx1 data after reset");
      check_dac(tx2_data_o, '0, "tx2 data after reset");
      check_bit(dac1_ready_o, 1'b1, "dac1 ready after reset");
      check_bit(dac2_ready_o, 1'b1, "dac2 ready after reset");

      for (int r = 0; r < num_rec; r++)
      begin
         for (int f = 0; f < REC_W; f++)
            rec[f] = tdata[r*REC_W + f];
         case (rec[0])
            16'd1:   rx_step();
            16'd2:   tx_pair();
            default: spi_step();
         endcase
      end

      $display("TEST OK");
      $finish;
   end

endmodule

// File: verification/lms_frontend_testdata.txt
// kind 1 RX : ch iqsel word exp_valid exp_i exp_q 0
// kind 2 TX : ch i q exp_i_slot exp_q_slot 0 0
// kind 3 SPI: sen_n sclk mosi dev_miso exp_dev_sclk exp_dev_mosi exp_miso
// Plain pairs on each channel
1 1 1 123 0 0000 0000 0
1 1 0 456 1 048C 1158 0
1 2 1 ABC 0 0000 0000 0
1 2 0 0F0 1 2AF0 03C0 0
// Orphan Q words
1 1 0 777 0 0000 0000 0
1 2 0 555 0 0000 0000 0
// Later I replaces the held one
1 1 1 001 0 0000 0000 0
1 1 1 FFF 0 0000 0000 0
1 1 0 800 1 3FFC 2000 0
// Channels interleaved in time
1 2 1 3A5 0 0000 0000 0
1 1 1 5A3 0 0000 0000 0
1 2 0 0C3 1 0E94 030C 0
1 1 0 7E1 1 168C 1F84 0
1 1 0 000 0 0000 0000 0
// Transmit pairs
2 1 123 456 123 456 0 0
2 2 ABC DEF ABC DEF 0 0
2 1 FFF 001 FFF 001 0 0
2 1 800 7FF 800 7FF 0 0
2 2 5A5 A5A 5A5 A5A 0 0
2 2 000 FFF 000 FFF 0 0
2 1 321 654 321 654 0 0
2 2 135 246 135 246 0 0
// SPI, device 0 aux DAC, 1 LMS 1, 2 LMS 2
3 6 1 1 7 1 1 1
3 6 1 0 6 1 0 0
3 5 1 1 2 2 2 1
3 5 0 1 5 0 2 0
3 3 1 1 4 4 4 1
3 3 1 0 3 4 0 0
// No device enabled
3 7 1 1 7 0 0 0
3 7 0 0 0 0 0 0
